/* include/regFile_macros.svh */
////////////////////
// Widths, counts and special register codes
////////////////////
`ifndef REGFILE_MACROS_SVH
`define REGFILE_MACROS_SVH

`define REG_WIDTH        64
`define REG_ID_WIDTH     6
`define GPR_INDEX_WIDTH  5
`define GPR_COUNT        32
`define ADDR_WIDTH       48    // PC, GBR, LR
`define IMM_WIDTH        33    // Immediate including its sign bit
`define LANE_COUNT       3
`define READ_PORTS       6

// Codes with bit 5 set
`define SPR_DLR  6'h20
`define SPR_DHR  6'h21
`define SPR_SP   6'h2F
`define SPR_PC   6'h30
`define SPR_GBR  6'h31
`define SPR_LR   6'h32
`define SPR_IMM  6'h3E
`define SPR_ZZR  6'h3F    // Zero, also the id of an idle lane

`endif

/* logic/gprBankArray.sv */
////////////////////
// Three GPR write banks, live-value table
// and six combinational bank read muxes
////////////////////
`include "regFile_macros.svh"

module gprBankArray (
	input  logic                 clock,
	input  logic                 rstN,
	input  logic                 hold,
	input  regFilePkg::regId_t   readId [`READ_PORTS],
	input  regFilePkg::regId_t   wbId [`LANE_COUNT],
	input  regFilePkg::regWord_t wbVal [`LANE_COUNT],
	output regFilePkg::regWord_t bankVal [`READ_PORTS]
);

	regFilePkg::regWord_t bankMem [`LANE_COUNT][`GPR_COUNT];    // One bank per lane
	regFilePkg::bankSel_t liveTable [`GPR_COUNT];

	// Each lane only ever writes its own bank
	always_ff @(posedge clock) begin
		if (!hold) begin
			for (int lane = 0; lane < `LANE_COUNT; lane++) begin
				if (!wbId[lane].gpr.isSpecial) begin
					bankMem[lane][wbId[lane].gpr.index] <= wbVal[lane];
				end
			end
		end
	end

	// Later lanes overwrite earlier ones, so C beats B beats A
	always_ff @(posedge clock) begin
		if (!rstN) begin
			for (int i = 0; i < `GPR_COUNT; i++) begin
				liveTable[i] <= regFilePkg::selBankA;
			end
		end else if (!hold) begin
			for (int lane = 0; lane < `LANE_COUNT; lane++) begin
				if (!wbId[lane].gpr.isSpecial) begin
					liveTable[wbId[lane].gpr.index] <= regFilePkg::bankSel_t'(lane);
				end
			end
		end
	end

	always_comb begin
		logic [`GPR_INDEX_WIDTH-1:0] idx;

		for (int port = 0; port < `READ_PORTS; port++) begin
			idx = readId[port].gpr.index;    // isSpecial ignored, caller picks
			case (liveTable[idx])
				regFilePkg::selBankB: bankVal[port] = bankMem[1][idx];
				regFilePkg::selBankC: bankVal[port] = bankMem[2][idx];
				default:              bankVal[port] = bankMem[0][idx];
			endcase
		end
	end

endmodule

/* logic/operandForward.sv */
////////////////////
// Bank/special select and EX1/EX2 bypass
////////////////////
`include "regFile_macros.svh"

module operandForward (
	input  regFilePkg::regId_t      readId [`READ_PORTS],
	input  regFilePkg::regWord_t    bankVal [`READ_PORTS],
	input  regFilePkg::regWord_t    specVal [`READ_PORTS],
	input  logic [`READ_PORTS-1:0]  isConst,
	input  regFilePkg::regId_t      ex1Id [`LANE_COUNT],
	input  regFilePkg::regId_t      ex2Id [`LANE_COUNT],
	input  regFilePkg::regWord_t    ex1Val [`LANE_COUNT],
	input  regFilePkg::regWord_t    ex2Val [`LANE_COUNT],
	output regFilePkg::regWord_t    sourceVal [`READ_PORTS]
);

	// Matches are applied lowest priority first, so the last hit stands:
	// C2, B2, A2, C1, B1, A1
	always_comb begin
		for (int port = 0; port < `READ_PORTS; port++) begin
			sourceVal[port] = readId[port].gpr.isSpecial ? specVal[port] : bankVal[port];

			// IMM and ZZR never bypass, which also keeps idle lanes out
			if (!isConst[port]) begin
				for (int lane = `LANE_COUNT - 1; lane >= 0; lane--) begin
					if (ex2Id[lane].spr == readId[port].spr) begin
						sourceVal[port] = ex2Val[lane];
					end
				end
				for (int lane = `LANE_COUNT - 1; lane >= 0; lane--) begin
					if (ex1Id[lane].spr == readId[port].spr) begin
						sourceVal[port] = ex1Val[lane];    // Youngest result
					end
				end
			end
		end
	end

endmodule

/* logic/regFilePkg.sv */
////////////////////
// Register id union, word and bank select types
////////////////////
`include "regFile_macros.svh"

package regFilePkg;

	typedef logic [`REG_WIDTH-1:0] regWord_t;

	// GPR view of a register code
	typedef struct packed {
		logic isSpecial;
		logic [`GPR_INDEX_WIDTH-1:0] index;
	} gprView_t;

	// Same 6 bits, seen as a bank index or as a whole special code
	typedef union packed {
		gprView_t gpr;
		logic [`REG_ID_WIDTH-1:0] spr;
	} regId_t;

	typedef enum logic [1:0] {
		selBankA = 2'd0,
		selBankB = 2'd1,
		selBankC = 2'd2
	} bankSel_t;

endpackage

/* logic/regFileTop.sv */
////////////////////
// Register file top, 6 reads and 3 write lanes
////////////////////
`include "regFile_macros.svh"

module regFileTop (
	input  logic                    clock,
	input  logic                    rstN,
	input  logic                    hold,
	input  regFilePkg::regId_t      readId [`READ_PORTS],
	output regFilePkg::regWord_t    sourceVal [`READ_PORTS],
	input  regFilePkg::regId_t      ex1Id [`LANE_COUNT],
	input  regFilePkg::regId_t      ex2Id [`LANE_COUNT],
	input  regFilePkg::regWord_t    ex1Val [`LANE_COUNT],
	input  regFilePkg::regWord_t    ex2Val [`LANE_COUNT],
	input  logic [`ADDR_WIDTH-1:0]  pcVal,
	input  logic [`ADDR_WIDTH-1:0]  gbrVal,
	input  logic [`ADDR_WIDTH-1:0]  lrVal,
	input  logic [`IMM_WIDTH-1:0]   immVal [`LANE_COUNT],
	input  regFilePkg::regWord_t    dlrIn,
	input  regFilePkg::regWord_t    dhrIn,
	input  regFilePkg::regWord_t    spIn,
	output regFilePkg::regWord_t    dlrOut,
	output regFilePkg::regWord_t    dhrOut,
	output regFilePkg::regWord_t    spOut
);

	regFilePkg::regWord_t bankVal [`READ_PORTS];
	regFilePkg::regWord_t specVal [`READ_PORTS];
	logic [`READ_PORTS-1:0] isConst;

	// EX2 lanes double as writeback
	gprBankArray gprBankArray_i (
		.clock(clock), .rstN(rstN), .hold(hold),
		.readId(readId),
		.wbId(ex2Id), .wbVal(ex2Val),
		.bankVal(bankVal)
	);

	sprFile sprFile_i (
		.clock(clock), .rstN(rstN), .hold(hold),
		.readId(readId),
		.wbId(ex2Id), .wbVal(ex2Val),
		.dlrIn(dlrIn), .dhrIn(dhrIn), .spIn(spIn),
		.pcVal(pcVal), .gbrVal(gbrVal), .lrVal(lrVal),
		.immVal(immVal),
		.specVal(specVal), .isConst(isConst),
		.dlrOut(dlrOut), .dhrOut(dhrOut), .spOut(spOut)
	);

	operandForward operandForward_i (
		.readId(readId),
		.bankVal(bankVal), .specVal(specVal), .isConst(isConst),
		.ex1Id(ex1Id), .ex2Id(ex2Id),
		.ex1Val(ex1Val), .ex2Val(ex2Val),
		.sourceVal(sourceVal)
	);

endmodule

/* logic/sprFile.sv */
////////////////////
// DLR, DHR and SP registers with lane update
// and special code decode for six read ports
////////////////////
`include "regFile_macros.svh"

module sprFile (
	input  logic                    clock,
	input  logic                    rstN,
	input  logic                    hold,
	input  regFilePkg::regId_t      readId [`READ_PORTS],
	input  regFilePkg::regId_t      wbId [`LANE_COUNT],
	input  regFilePkg::regWord_t    wbVal [`LANE_COUNT],
	input  regFilePkg::regWord_t    dlrIn,
	input  regFilePkg::regWord_t    dhrIn,
	input  regFilePkg::regWord_t    spIn,
	input  logic [`ADDR_WIDTH-1:0]  pcVal,
	input  logic [`ADDR_WIDTH-1:0]  gbrVal,
	input  logic [`ADDR_WIDTH-1:0]  lrVal,
	input  logic [`IMM_WIDTH-1:0]   immVal [`LANE_COUNT],
	output regFilePkg::regWord_t    specVal [`READ_PORTS],
	output logic [`READ_PORTS-1:0]  isConst,
	output regFilePkg::regWord_t    dlrOut,
	output regFilePkg::regWord_t    dhrOut,
	output regFilePkg::regWord_t    spOut
);

	localparam int sprCount = 3;
	localparam logic [`REG_ID_WIDTH-1:0] sprCode [sprCount] = '{`SPR_DLR, `SPR_DHR, `SPR_SP};

	regFilePkg::regWord_t sprReg [sprCount];    // 0 DLR, 1 DHR, 2 SP
	regFilePkg::regWord_t sprIn [sprCount];

	assign sprIn[0] = dlrIn;
	assign sprIn[1] = dhrIn;
	assign sprIn[2] = spIn;

	// External input unless a lane targets the code; walk C to A so A wins
	always_ff @(posedge clock) begin
		if (!rstN) begin
			for (int s = 0; s < sprCount; s++) begin
				sprReg[s] <= '0;
			end
		end else if (!hold) begin
			for (int s = 0; s < sprCount; s++) begin
				sprReg[s] <= sprIn[s];
				for (int lane = `LANE_COUNT - 1; lane >= 0; lane--) begin
					if (wbId[lane].spr == sprCode[s]) begin
						sprReg[s] <= wbVal[lane];
					end
				end
			end
		end
	end

	always_comb begin
		for (int port = 0; port < `READ_PORTS; port++) begin
			isConst[port] = 1'b0;
			case (readId[port].spr)
				`SPR_DLR: specVal[port] = sprReg[0];
				`SPR_DHR: specVal[port] = sprReg[1];
				`SPR_SP:  specVal[port] = sprReg[2];
				`SPR_PC:  specVal[port] = {{(`REG_WIDTH - `ADDR_WIDTH){1'b0}}, pcVal};
				`SPR_GBR: specVal[port] = {{(`REG_WIDTH - `ADDR_WIDTH){1'b0}}, gbrVal};
				`SPR_LR:  specVal[port] = {{(`REG_WIDTH - `ADDR_WIDTH){1'b0}}, lrVal};
				`SPR_IMM: begin
					// Ports 2n and 2n+1 belong to lane n
					specVal[port] = {{(`REG_WIDTH - `IMM_WIDTH){immVal[port / 2][`IMM_WIDTH-1]}},
						immVal[port / 2]};
					isConst[port] = 1'b1;
				end
				`SPR_ZZR: begin
					specVal[port] = '0;
					isConst[port] = 1'b1;
				end
				default:  specVal[port] = '0;    // Unknown codes read as zero
			endcase
		end
	end

	assign dlrOut = sprReg[0];
	assign dhrOut = sprReg[1];
	assign spOut  = sprReg[2];

endmodule

/* runSim.sh */
#!/bin/sh
# Build and run the register file testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module regFileTb -Mdir obj_dir -f sources.f

simOut=$(./obj_dir/VregFileTb)
echo "$simOut"
echo "$simOut" | grep -q "^TEST PASS$"

/* sources.f */
+incdir+include
logic/regFilePkg.sv
logic/gprBankArray.sv
logic/sprFile.sv
logic/operandForward.sv
logic/regFileTop.sv
test/regFileChecker.sv
test/regFileTb.sv

/* test/regFileChecker.sv */
////////////////////
// Output checker for the register file testbench
////////////////////
`include "regFile_macros.svh"

module regFileChecker #(
	parameter int sampleDelay = 36    // From the rising edge, just short of the next one
) (
	input  logic                   clock,
	input  logic                   checkEn,
	input  int                     rowIndex,
	input  logic [`REG_WIDTH-1:0]  sourceVal [`READ_PORTS],
	input  logic [`REG_WIDTH-1:0]  expSrc [`READ_PORTS],
	input  logic [`REG_WIDTH-1:0]  dlrOut,
	input  logic [`REG_WIDTH-1:0]  dhrOut,
	input  logic [`REG_WIDTH-1:0]  spOut,
	input  logic [`REG_WIDTH-1:0]  expDlr,
	input  logic [`REG_WIDTH-1:0]  expDhr,
	input  logic [`REG_WIDTH-1:0]  expSp,
	output int                     errorCount,
	output int                     rowsChecked
);

	int errCount = 0;
	int checkedCount = 0;

	assign errorCount  = errCount;
	assign rowsChecked = checkedCount;

	task automatic compareWord(input string name, input logic [`REG_WIDTH-1:0] got,
		input logic [`REG_WIDTH-1:0] exp);
		if (got !== exp) begin
			errCount++;
			$display("ERR row %0d %s: got %h, expected %h", rowIndex, name, got, exp);
		end
	endtask

	always @(posedge clock) begin
		#sampleDelay;
		if (checkEn) begin
			for (int p = 0; p < `READ_PORTS; p++) begin
				compareWord($sformatf("sourceVal[%0d]", p), sourceVal[p], expSrc[p]);
			end
			compareWord("dlrOut", dlrOut, expDlr);
			compareWord("dhrOut", dhrOut, expDhr);
			compareWord("spOut", spOut, expSp);
			checkedCount++;
		end
	end

endmodule

/* test/regFileTb.sv */
////////////////////
// Register file testbench with clock, reset,
// stimulus table, driving loop and watchdog
////////////////////
`include "regFile_macros.svh"

module regFileTb;

	localparam int clockPeriod = 40;
	localparam int driveDelay  = 2;
	localparam int resetCycles = 5;
	localparam int rowCount    = 12;
	localparam int timeoutTime = (rowCount + resetCycles + 10) * clockPeriod;

	// Index 0 is the leftmost element, so rows read port 0 first
	typedef logic [0:`READ_PORTS-1][`REG_ID_WIDTH-1:0] portIds_t;
	typedef logic [0:`READ_PORTS-1][`REG_WIDTH-1:0]    portWords_t;
	typedef logic [0:`LANE_COUNT-1][`REG_ID_WIDTH-1:0] laneIds_t;
	typedef logic [0:`LANE_COUNT-1][`REG_WIDTH-1:0]    laneWords_t;
	typedef logic [0:2][`REG_WIDTH-1:0]                sprWords_t;    // DLR, DHR, SP

	typedef struct packed {
		portIds_t   rd;
		laneIds_t   ex1Id;
		laneWords_t ex1Val;
		laneIds_t   ex2Id;
		laneWords_t ex2Val;    // Also the writeback lanes
		sprWords_t  sprIn;
		logic       hold;
		portWords_t expSrc;
		sprWords_t  expSpr;
	} stimRow_t;

	localparam laneIds_t   idleIds = {`LANE_COUNT{`SPR_ZZR}};
	localparam laneWords_t noVals  = '0;

	// Constant inputs and their extended forms
	localparam logic [`ADDR_WIDTH-1:0] pcConst  = 48'h8000_1234_5678;
	localparam logic [`ADDR_WIDTH-1:0] gbrConst = 48'hFFFF_0000_0040;
	localparam logic [`ADDR_WIDTH-1:0] lrConst  = 48'h0000_0BAD_F00D;
	localparam logic [`REG_WIDTH-1:0] pcExp   = 64'h0000_8000_1234_5678;
	localparam logic [`REG_WIDTH-1:0] gbrExp  = 64'h0000_FFFF_0000_0040;
	localparam logic [`REG_WIDTH-1:0] lrExp   = 64'h0000_0000_0BAD_F00D;
	localparam logic [`REG_WIDTH-1:0] immAExp = 64'hFFFF_FFFF_FFFF_FFF0;    // 33'h1_FFFF_FFF0
	localparam logic [`REG_WIDTH-1:0] immBExp = 64'hFFFF_FFFF_0000_0005;    // 33'h1_0000_0005
	localparam logic [`REG_WIDTH-1:0] immCExp = 64'h0000_0000_8000_0000;    // 33'h0_8000_0000

	logic clock, rstN, hold, checkEn;
	logic [`REG_ID_WIDTH-1:0] readId [`READ_PORTS];
	logic [`REG_WIDTH-1:0] sourceVal [`READ_PORTS];
	logic [`REG_WIDTH-1:0] expSrc [`READ_PORTS];
	logic [`REG_ID_WIDTH-1:0] ex1Id [`LANE_COUNT];
	logic [`REG_ID_WIDTH-1:0] ex2Id [`LANE_COUNT];
	logic [`REG_WIDTH-1:0] ex1Val [`LANE_COUNT];
	logic [`REG_WIDTH-1:0] ex2Val [`LANE_COUNT];
	logic [`ADDR_WIDTH-1:0] pcVal, gbrVal, lrVal;
	logic [`IMM_WIDTH-1:0] immVal [`LANE_COUNT];
	logic [`REG_WIDTH-1:0] dlrIn, dhrIn, spIn, dlrOut, dhrOut, spOut;
	logic [`REG_WIDTH-1:0] expDlr, expDhr, expSp;
	int rowIndex, errorCount, rowsChecked;

	// Columns: rd, ex1Id, ex1Val, ex2Id, ex2Val, sprIn, hold, expSrc, expSpr
	stimRow_t rows [rowCount] = '{
		'{{`SPR_DLR, `SPR_DHR, `SPR_SP, `SPR_ZZR, `SPR_PC, `SPR_IMM}, idleIds, noVals,
			{6'd1, 6'd2, 6'd3}, {64'hA1, 64'hB2, 64'hC3}, {64'h1111, 64'h2222, 64'h3333}, 1'b0,
			{64'h0, 64'h0, 64'h0, 64'h0, pcExp, immCExp}, {64'h0, 64'h0, 64'h0}},
		'{{6'd1, 6'd2, 6'd3, 6'd1, 6'd2, 6'd3}, idleIds, noVals,
			idleIds, noVals, {64'h4444, 64'h5555, 64'h6666}, 1'b0,
			{64'hA1, 64'hB2, 64'hC3, 64'hA1, 64'hB2, 64'hC3}, {64'h1111, 64'h2222, 64'h3333}},
		// All three lanes hit r5
		'{{6'd3, 6'd2, 6'd1, `SPR_GBR, `SPR_LR, 6'h25}, idleIds, noVals,
			{6'd5, 6'd5, 6'd5}, {64'h5A, 64'h5B, 64'h5C}, {64'h4444, 64'h5555, 64'h6666}, 1'b0,
			{64'hC3, 64'hB2, 64'hA1, gbrExp, lrExp, 64'h0}, {64'h4444, 64'h5555, 64'h6666}},
		'{{6'd5, 6'd5, 6'd5, 6'd1, 6'd2, 6'd3}, idleIds, noVals,
			{6'd6, 6'd6, `SPR_ZZR}, {64'h6A, 64'h6B, 64'h0}, {64'h4444, 64'h5555, 64'h6666}, 1'b0,
			{64'h5C, 64'h5C, 64'h5C, 64'hA1, 64'hB2, 64'hC3}, {64'h4444, 64'h5555, 64'h6666}},
		// Lane A alone rewrites r5, port 1 sees it bypassed
		'{{6'd6, 6'd5, `SPR_ZZR, `SPR_ZZR, `SPR_ZZR, `SPR_ZZR}, idleIds, noVals,
			{6'd5, `SPR_ZZR, `SPR_ZZR}, {64'h5D, 64'h0, 64'h0}, {64'h4444, 64'h5555, 64'h6666},
			1'b0, {64'h6B, 64'h5D, 64'h0, 64'h0, 64'h0, 64'h0}, {64'h4444, 64'h5555, 64'h6666}},
		'{{6'd5, 6'd6, `SPR_ZZR, `SPR_ZZR, `SPR_ZZR, `SPR_ZZR}, idleIds, noVals,
			idleIds, noVals, {64'h8888, 64'h9999, 64'hAAAA}, 1'b0,
			{64'h5D, 64'h6B, 64'h0, 64'h0, 64'h0, 64'h0}, {64'h4444, 64'h5555, 64'h6666}},
		// Bypass priority, lane C writes DLR
		'{{6'd1, 6'd2, 6'd3, `SPR_DLR, 6'd5, `SPR_IMM},
			{6'd1, 6'd1, 6'd2}, {64'hE1A0, 64'hE1B0, 64'hE1C0},
			{6'd2, 6'd3, `SPR_DLR}, {64'hE2A0, 64'hE2B0, 64'hE2C0},
			{64'h8888, 64'h9999, 64'hAAAA}, 1'b0,
			{64'hE1A0, 64'hE1C0, 64'hE2B0, 64'hE2C0, 64'h5D, immCExp},
			{64'h8888, 64'h9999, 64'hAAAA}},
		'{{`SPR_ZZR, `SPR_IMM, `SPR_IMM, 6'd4, 6'd2, `SPR_DLR},
			{`SPR_ZZR, `SPR_IMM, `SPR_ZZR}, {64'hDEAD, 64'hBEEF, 64'h0},
			{6'd4, `SPR_ZZR, 6'd4}, {64'h44A0, 64'h0, 64'h44C0},
			{64'h8888, 64'h9999, 64'hAAAA}, 1'b0,
			{64'h0, immAExp, immBExp, 64'h44A0, 64'hE2A0, 64'hE2C0},
			{64'hE2C0, 64'h9999, 64'hAAAA}},
		'{{6'd4, 6'd3, `SPR_SP, `SPR_DHR, `SPR_IMM, `SPR_ZZR}, idleIds, noVals,
			{`SPR_DHR, `SPR_DHR, `SPR_SP}, {64'hD0A0, 64'hD0B0, 64'h5C00},
			{64'hCCCC, 64'hDDDD, 64'hEEEE}, 1'b0,
			{64'h44C0, 64'hE2B0, 64'h5C00, 64'hD0A0, immCExp, 64'h0},
			{64'h8888, 64'h9999, 64'hAAAA}},
		// Hold, so neither the r4 nor the DLR write lands
		'{{6'd1, `SPR_DHR, `SPR_SP, `SPR_DLR, `SPR_IMM, 6'd5}, idleIds, noVals,
			{6'd4, `SPR_DLR, `SPR_ZZR}, {64'h9900, 64'h7700, 64'h0},
			{64'hF0F0, 64'hF1F1, 64'hF2F2}, 1'b1,
			{64'hA1, 64'hD0A0, 64'h5C00, 64'h7700, immCExp, 64'h5D},
			{64'hCCCC, 64'hD0A0, 64'h5C00}},
		'{{6'd4, `SPR_DLR, `SPR_DHR, `SPR_SP, 6'd1, `SPR_ZZR}, idleIds, noVals,
			{`SPR_ZZR, `SPR_DLR, `SPR_DLR}, {64'h0, 64'hBB00, 64'hCC00},
			{64'h1212, 64'h3434, 64'h5656}, 1'b0,
			{64'h44C0, 64'hBB00, 64'hD0A0, 64'h5C00, 64'hA1, 64'h0},
			{64'hCCCC, 64'hD0A0, 64'h5C00}},
		'{{`SPR_DLR, `SPR_DHR, `SPR_SP, 6'd4, 6'd2, 6'd3}, idleIds, noVals,
			idleIds, noVals, {64'h1212, 64'h3434, 64'h5656}, 1'b0,
			{64'hBB00, 64'h3434, 64'h5656, 64'h44C0, 64'hE2A0, 64'hE2B0},
			{64'hBB00, 64'h3434, 64'h5656}}
	};

	regFileTop dut_i (
		.clock(clock), .rstN(rstN), .hold(hold),
		.readId(readId), .sourceVal(sourceVal),
		.ex1Id(ex1Id), .ex2Id(ex2Id), .ex1Val(ex1Val), .ex2Val(ex2Val),
		.pcVal(pcVal), .gbrVal(gbrVal), .lrVal(lrVal), .immVal(immVal),
		.dlrIn(dlrIn), .dhrIn(dhrIn), .spIn(spIn),
		.dlrOut(dlrOut), .dhrOut(dhrOut), .spOut(spOut)
	);

	regFileChecker #(.sampleDelay(clockPeriod - 4)) checker_i (
		.clock(clock), .checkEn(checkEn), .rowIndex(rowIndex),
		.sourceVal(sourceVal), .expSrc(expSrc),
		.dlrOut(dlrOut), .dhrOut(dhrOut), .spOut(spOut),
		.expDlr(expDlr), .expDhr(expDhr), .expSp(expSp),
		.errorCount(errorCount), .rowsChecked(rowsChecked)
	);

	initial clock = 1'b0;
	always #(clockPeriod / 2) clock = ~clock;

	task automatic applyRow(input int r);
		stimRow_t row;
		row = rows[r];
		hold = row.hold;
		dlrIn = row.sprIn[0];
		dhrIn = row.sprIn[1];
		spIn = row.sprIn[2];
		for (int p = 0; p < `READ_PORTS; p++) begin
			readId[p] = row.rd[p];
			expSrc[p] = row.expSrc[p];
		end
		for (int l = 0; l < `LANE_COUNT; l++) begin
			ex1Id[l] = row.ex1Id[l];
			ex1Val[l] = row.ex1Val[l];
			ex2Id[l] = row.ex2Id[l];
			ex2Val[l] = row.ex2Val[l];
		end
		expDlr = row.expSpr[0];
		expDhr = row.expSpr[1];
		expSp = row.expSpr[2];
		rowIndex = r;
		checkEn = 1'b1;
	endtask

	initial begin
		rstN = 1'b0;
		hold = 1'b0;
		checkEn = 1'b0;
		rowIndex = 0;
		{dlrIn, dhrIn, spIn, expDlr, expDhr, expSp} = '0;
		pcVal = pcConst;
		gbrVal = gbrConst;
		lrVal = lrConst;
		immVal[0] = 33'h1_FFFF_FFF0;
		immVal[1] = 33'h1_0000_0005;
		immVal[2] = 33'h0_8000_0000;
		for (int p = 0; p < `READ_PORTS; p++) begin
			readId[p] = `SPR_ZZR;
			expSrc[p] = '0;
		end
		for (int l = 0; l < `LANE_COUNT; l++) begin
			ex1Id[l] = `SPR_ZZR;    // Idle lanes
			ex2Id[l] = `SPR_ZZR;
			ex1Val[l] = '0;
			ex2Val[l] = '0;
		end
		repeat (resetCycles) @(posedge clock);
		#driveDelay;
		rstN = 1'b1;
		for (int r = 0; r < rowCount; r++) begin
			applyRow(r);
			@(posedge clock);
			#driveDelay;
		end
		checkEn = 1'b0;
		$display("Rows checked: %0d, errors: %0d", rowsChecked, errorCount);
		if (errorCount == 0 && rowsChecked == rowCount) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	initial begin
		#timeoutTime;
		$display("Timeout: stimulus did not complete within %0d time units", timeoutTime);
		$display("TEST FAIL");
		$finish;
	end

endmodule
